// File: Bender.yml
package:
  name: mul_iter

sources:
  - mul_types_pkg.sv
  - mul_ctrl_pkg.sv
  - operand_tracker.sv
  - product_accumulator.sv
  - product_output.sv
  - mul_top.sv
  - target: simulation
    files:
      - tb_mul_top.sv

// File: mul_ctrl_pkg.sv
`default_nettype none

package mul_ctrl_pkg;

        ////////////////////////////////////////////////////
        // multiply phases
        ////////////////////////////////////////////////////

        // bit 1 picks the high lane of a, bit 0 the high lane of b
        typedef enum logic [1:0] {
                LO_LO = 2'd0,
                LO_HI = 2'd1,
                HI_LO = 2'd2,
                HI_HI = 2'd3
        } phase_t;

        ////////////////////////////////////////////////////
        // latency
        ////////////////////////////////////////////////////

        // rising edges from the capturing edge to the edge that raises done
        localparam int unsigned MUL_LATENCY = 5;

endpackage

`default_nettype wire

// File: mul_top.sv
`default_nettype none

module mul_top (
        input  wire                           clk,
        input  wire                           arst_n,
        input  wire mul_types_pkg::operand_t  op_a,
        input  wire mul_types_pkg::operand_t  op_b,
        output mul_types_pkg::product_t       product,
        output logic                          product_valid,
        output logic                          done
);

        import mul_types_pkg::*;

        operand_pair_t pair;
        logic          start;
        product_t      result;
        logic          result_strobe;

        ////////////////////////////////////////////////////
        // input side
        ////////////////////////////////////////////////////

        operand_tracker u_operand_tracker (
                .clk    (clk),
                .arst_n (arst_n),
                .op_a   (op_a),
                .op_b   (op_b),
                .pair   (pair),
                .start  (start)
        );

        ////////////////////////////////////////////////////
        // processing part
        ////////////////////////////////////////////////////

        product_accumulator u_product_accumulator (
                .clk           (clk),
                .arst_n        (arst_n),
                .pair          (pair),
                .start         (start),
                .result        (result),
                .result_strobe (result_strobe)
        );

        ////////////////////////////////////////////////////
        // output side
        ////////////////////////////////////////////////////

        product_output u_product_output (
                .clk           (clk),
                .arst_n        (arst_n),
                .start         (start),
                .result        (result),
                .result_strobe (result_strobe),
                .product       (product),
                .product_valid (product_valid),
                .done          (done)
        );

endmodule

`default_nettype wire

// File: mul_types_pkg.sv
`default_nettype none

package mul_types_pkg;

        ////////////////////////////////////////////////////
        // operand and lane widths
        ////////////////////////////////////////////////////

        // one unsigned multiplier operand
        typedef logic [31:0] operand_t;

        // one 16-bit half of an operand or of the accumulator
        typedef logic [15:0] lane_t;

        // full unsigned product
        typedef logic [63:0] product_t;

        ////////////////////////////////////////////////////
        // compound types
        ////////////////////////////////////////////////////

        // pair captured by the input side
        typedef struct packed {
                operand_t a;
                operand_t b;
        } operand_pair_t;

        // accumulator word, lane 0 is the least significant
        typedef union packed {
                product_t    word;
                lane_t [3:0] lanes;
        } acc_word_u;

endpackage

`default_nettype wire

// File: operand_tracker.sv
`default_nettype none

module operand_tracker (
        input  wire                           clk,
        input  wire                           arst_n,
        input  wire mul_types_pkg::operand_t  op_a,
        input  wire mul_types_pkg::operand_t  op_b,
        output mul_types_pkg::operand_pair_t  pair,
        output logic                          start
);

        import mul_types_pkg::*;

        // set once the first pair after reset has been taken
        logic captured;
        logic changed;

        // a new pair is taken on any difference, or unconditionally the first time
        always_comb begin
                changed = !captured || (op_a != pair.a) || (op_b != pair.b);
        end

        ////////////////////////////////////////////////////
        // control
        ////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        captured <= 1'b0;
                        start    <= 1'b0;
                end else begin
                        start <= changed;
                        if (changed) begin
                                captured <= 1'b1;
                        end
                end
        end

        ////////////////////////////////////////////////////
        // held pair
        ////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (changed) begin
                        pair.a <= op_a;
                        pair.b <= op_b;
                end
        end

endmodule

`default_nettype wire

// File: product_accumulator.sv
`default_nettype none

module product_accumulator (
        input  wire                                clk,
        input  wire                                arst_n,
        input  wire mul_types_pkg::operand_pair_t  pair,
        input  wire                                start,
        output mul_types_pkg::product_t            result,
        output logic                               result_strobe
);

        import mul_types_pkg::*;
        import mul_ctrl_pkg::*;

        acc_word_u acc;
        acc_word_u base;
        acc_word_u next_acc;
        phase_t    phase;
        phase_t    cur_phase;
        logic      busy;

        lane_t       a_lane;
        lane_t       b_lane;
        logic [31:0] partial;
        logic [1:0]  off;
        logic [1:0]  off_hi;
        logic [1:0]  off_carry;
        logic [31:0] window;
        logic [32:0] sum;

        ////////////////////////////////////////////////////
        // lane selection and 16x16 multiply
        ////////////////////////////////////////////////////

        // start forces the first phase on the same edge
        always_comb begin
                cur_phase = start ? LO_LO : phase;
                a_lane    = cur_phase[1] ? pair.a[31:16] : pair.a[15:0];
                b_lane    = cur_phase[0] ? pair.b[31:16] : pair.b[15:0];
                partial   = a_lane * b_lane;
        end

        ////////////////////////////////////////////////////
        // windowed accumulation
        ////////////////////////////////////////////////////

        // lane offset is 0, 1, 1, 2 for the four phases
        always_comb begin
                off       = {1'b0, cur_phase[1]} + {1'b0, cur_phase[0]};
                off_hi    = off + 2'd1;
                off_carry = off + 2'd2;

                base = acc;
                if (start) begin
                        base.word = '0;
                end

                window = {base.lanes[off_hi], base.lanes[off]};
                sum    = {1'b0, window} + {1'b0, partial};

                next_acc                = base;
                next_acc.lanes[off]     = sum[15:0];
                next_acc.lanes[off_hi]  = sum[31:16];
                // no lane above the top window, the full product fits in 64 bits
                if (off != 2'd2) begin
                        next_acc.lanes[off_carry] = base.lanes[off_carry] + lane_t'(sum[32]);
                end
        end

        ////////////////////////////////////////////////////
        // phase sequencer
        ////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        acc.word      <= '0;
                        phase         <= LO_LO;
                        busy          <= 1'b0;
                        result_strobe <= 1'b0;
                end else if (start) begin
                        // a restart drops whatever run was in flight
                        acc           <= next_acc;
                        phase         <= LO_HI;
                        busy          <= 1'b1;
                        result_strobe <= 1'b0;
                end else if (busy) begin
                        acc           <= next_acc;
                        phase         <= phase_t'(phase + 2'd1);
                        busy          <= (phase != HI_HI);
                        result_strobe <= (phase == HI_HI);
                end else begin
                        result_strobe <= 1'b0;
                end
        end

        assign result = acc.word;

endmodule

`default_nettype wire

// File: product_output.sv
`default_nettype none

module product_output (
        input  wire                           clk,
        input  wire                           arst_n,
        input  wire                           start,
        input  wire mul_types_pkg::product_t  result,
        input  wire                           result_strobe,
        output mul_types_pkg::product_t       product,
        output logic                          product_valid,
        output logic                          done
);

        import mul_types_pkg::*;

        product_t held;

        ////////////////////////////////////////////////////
        // product register and status
        ////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        held          <= '0;
                        product_valid <= 1'b0;
                        done          <= 1'b0;
                end else begin
                        // done lines up with the new product
                        done <= result_strobe;
                        if (result_strobe) begin
                                held <= result;
                        end
                        // new operands invalidate the old product but keep it visible
                        if (start) begin
                                product_valid <= 1'b0;
                        end else if (result_strobe) begin
                                product_valid <= 1'b1;
                        end
                end
        end

        assign product = held;

endmodule

`default_nettype wire

// File: tb_mul_top.sv
`default_nettype none

module tb_mul_top;

        import mul_types_pkg::*;
        import mul_ctrl_pkg::*;

        // one stimulus row: operands and how many cycles they stay applied
        typedef struct packed {
                operand_t   a;
                operand_t   b;
                logic [7:0] hold;
        } entry_t;

        localparam int          NUM_FIXED   = 14;
        localparam int          NUM_RANDOM  = 8;
        localparam int          NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
        localparam int          TIMEOUT     = 20;
        localparam logic [31:0] SEED        = 32'h27e5_2e9b;

        logic     clk = 1'b0;
        logic     arst_n;
        operand_t op_a;
        operand_t op_b;
        product_t product;
        logic     product_valid;
        logic     done;

        entry_t vectors [NUM_ENTRIES];
        int     errs;
        int     n_pass;
        int     n_fail;

        mul_top DUT (
                .clk           (clk),
                .arst_n        (arst_n),
                .op_a          (op_a),
                .op_b          (op_b),
                .product       (product),
                .product_valid (product_valid),
                .done          (done)
        );

        initial begin
                forever #5 clk = ~clk;
        end

        ////////////////////////////////////////////////////
        // helpers
        ////////////////////////////////////////////////////

        task automatic check_value(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH at %0t: %s expected %h got %h",
                                 $time, name, expected, actual);
                        errs++;
                end
        endtask

        function automatic entry_t make_entry(input operand_t a, input operand_t b,
                                              input int hold);
                entry_t e;
                e.a    = a;
                e.b    = b;
                e.hold = 8'(hold);
                return e;
        endfunction

        // hold below MUL_LATENCY means the pair is dropped before it finishes
        task automatic build_table();
                // row 0 repeats the reset-time operands, so only the first capture starts it
                vectors[0]  = make_entry(32'h0000_0001, 32'h0000_0001, 6);
                vectors[1]  = make_entry(32'h0000_0000, 32'h0000_0000, 6);
                vectors[2]  = make_entry(32'hffff_ffff, 32'hffff_ffff, 6);
                vectors[3]  = make_entry(32'h8000_0000, 32'h8000_0000, 6);
                vectors[4]  = make_entry(32'h8000_0000, 32'h0000_0001, 6);
                vectors[5]  = make_entry(32'h0000_ffff, 32'h0001_0001, 6);
                vectors[6]  = make_entry(32'hffff_0000, 32'h0001_ffff, 6);
                vectors[7]  = make_entry(32'h0001_0000, 32'h0000_8000, 6);
                vectors[8]  = make_entry(32'h1234_5678, 32'h9abc_def0, 2);
                vectors[9]  = make_entry(32'hdead_beef, 32'h0000_0003, 18);
                vectors[10] = make_entry(32'h0bad_cafe, 32'h1357_9bdf, 6);
                // same pair as row 9 again
                vectors[11] = make_entry(32'hdead_beef, 32'h0000_0003, 6);
                vectors[12] = make_entry(32'hffff_ffff, 32'h0000_0001, 2);
                vectors[13] = make_entry(32'h00ff_00ff, 32'hff00_ff00, 6);
                for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
                        vectors[i] = make_entry($urandom, $urandom, 6);
                end
        endtask

        ////////////////////////////////////////////////////
        // one table row, called on a falling edge
        ////////////////////////////////////////////////////

        task automatic run_entry(input int idx, input entry_t e);
                product_t expected;
                int       n;
                int       errs_before;
                logic     seen;

                expected    = product_t'(e.a) * product_t'(e.b);
                errs_before = errs;
                op_a        = e.a;
                op_b        = e.b;

                if (e.hold < MUL_LATENCY) begin
                        for (n = 1; n <= int'(e.hold); n++) begin
                                @(negedge clk);
                                if (done !== 1'b0) begin
                                        $display("test %0d: done pulsed for a pair that was dropped",
                                                 idx);
                                        errs++;
                                end
                        end
                        // start has cleared the valid level by now
                        if (e.hold >= 2) begin
                                check_value("product_valid", 64'(1'b0), 64'(product_valid));
                        end
                end else begin
                        n    = 0;
                        seen = 1'b0;
                        while (!seen && n < TIMEOUT) begin
                                @(negedge clk);
                                n++;
                                if (done === 1'b1) begin
                                        seen = 1'b1;
                                end else if (idx == 0) begin
                                        check_value("product_valid", 64'(1'b0), 64'(product_valid));
                                        check_value("product", 64'h0, product);
                                end
                        end
                        if (!seen) begin
                                $display("test %0d: done never came within %0d cycles", idx, TIMEOUT);
                                errs++;
                        end else begin
                                // the capturing edge comes before the first counted falling edge
                                check_value("done latency", 64'(MUL_LATENCY + 1), 64'(n));
                                check_value("product", expected, product);
                                check_value("product_valid", 64'(1'b1), 64'(product_valid));
                                // operands stay put, so nothing may move
                                for (int k = n; k < int'(e.hold); k++) begin
                                        @(negedge clk);
                                        check_value("done", 64'(1'b0), 64'(done));
                                        check_value("product", expected, product);
                                        check_value("product_valid", 64'(1'b1), 64'(product_valid));
                                end
                        end
                end

                if (errs == errs_before) begin
                        n_pass++;
                        $display("test %0d: a=%h b=%h hold=%0d ok", idx, e.a, e.b, e.hold);
                end else begin
                        n_fail++;
                        $display("test %0d: a=%h b=%h hold=%0d failed", idx, e.a, e.b, e.hold);
                end
        endtask

        ////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////

        initial begin
                int errs_before;

                errs   = 0;
                n_pass = 0;
                n_fail = 0;
                arst_n = 1'b0;
                op_a   = 32'h0000_0001;
                op_b   = 32'h0000_0001;
                void'($urandom(SEED));
                build_table();

                errs_before = errs;
                repeat (3) begin
                        @(negedge clk);
                        check_value("done", 64'(1'b0), 64'(done));
                        check_value("product_valid", 64'(1'b0), 64'(product_valid));
                        check_value("product", 64'h0, product);
                end
                if (errs == errs_before) begin
                        n_pass++;
                        $display("test reset: ok");
                end else begin
                        n_fail++;
                        $display("test reset: failed");
                end
                arst_n = 1'b1;

                for (int i = 0; i < NUM_ENTRIES; i++) begin
                        run_entry(i, vectors[i]);
                end

                $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errs);
                if (n_fail == 0 && errs == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: vlog.f
mul_types_pkg.sv
mul_ctrl_pkg.sv
operand_tracker.sv
product_accumulator.sv
product_output.sv
mul_top.sv
tb_mul_top.sv
